//--- Makefile
# Verilator build and run for the issue stage testbench.
VERILATOR ?= verilator
TOP       ?= issue_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/dispatch_if.sv
interface dispatch_if;
    import issue_pkg::*;

    logic     valid;                               // Holding register is occupied.
    fu_type_e fu_type;                             // Unit class of the held instruction.
    tag_t     dest_tag;                            // Tag this instruction will broadcast.
    tag_t     src_tag;                             // Tag the source operand waits on.
    logic     src_ready;                           // Source is available, wakeup included.
    logic     has_free;                            // Station has at least one empty slot.

    // Dispatch side drives the instruction and watches for room.
    modport producer (
        output valid, fu_type, dest_tag, src_tag, src_ready,
        input  has_free
    );

    // Station side takes the instruction and reports room.
    modport buffer (
        input  valid, fu_type, dest_tag, src_tag, src_ready,
        output has_free
    );

endinterface

//--- hdl/dispatch_unit.sv
module dispatch_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  issue_pkg::fu_type_e         in_fu_type,
    input  issue_pkg::tag_t             in_dest_tag,
    input  issue_pkg::tag_t             in_src_tag,
    input  logic                        in_src_ready,
    output logic                        in_ready,
    input  logic [issue_pkg::FU_COUNT-1:0] complete_valid,
    input  issue_pkg::tag_t             complete_tag [issue_pkg::FU_COUNT],
    dispatch_if.producer                dsp
);
    import issue_pkg::*;

    logic     hold_valid;                          // An instruction waits for a station slot.
    fu_type_e hold_fu;
    tag_t     hold_dest;
    tag_t     hold_src;
    logic     hold_src_rdy;                        // Source known ready when captured or since.
    logic     hold_hit;                            // Held source completes this cycle.
    logic     in_hit;                              // Arriving source completes this cycle.
    logic     accept;
    logic     handoff;

    assign hold_hit = tag_hit(complete_valid, complete_tag, hold_src);
    assign in_hit   = tag_hit(complete_valid, complete_tag, in_src_tag);
    assign handoff  = hold_valid && dsp.has_free;  // Station writes the entry at this edge.
    assign in_ready = !hold_valid || dsp.has_free; // Room now or room after the handoff.
    assign accept   = in_valid && in_ready;

    assign dsp.valid     = hold_valid;
    assign dsp.fu_type   = hold_fu;
    assign dsp.dest_tag  = hold_dest;
    assign dsp.src_tag   = hold_src;
    assign dsp.src_ready = hold_src_rdy || hold_hit;  // Same-cycle wakeup is passed along.

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid   <= 1'b0;
            hold_src_rdy <= 1'b0;
        end else begin
            if (accept) begin
                hold_valid   <= 1'b1;              // A handoff in the same cycle frees it first.
                hold_src_rdy <= in_src_ready || in_hit;
            end else begin
                if (handoff) hold_valid <= 1'b0;
                if (hold_hit) hold_src_rdy <= 1'b1;  // Completion while waiting for a slot.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_fu   <= in_fu_type;
            hold_dest <= in_dest_tag;
            hold_src  <= in_src_tag;
        end
    end

endmodule

//--- hdl/fu_cluster.sv
module fu_cluster (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [issue_pkg::FU_COUNT-1:0] issue_valid,
    input  issue_pkg::tag_t             issue_tag [issue_pkg::FU_COUNT],
    output logic [issue_pkg::FU_COUNT-1:0] fu_ready,
    output logic [issue_pkg::FU_COUNT-1:0] complete_valid,
    output issue_pkg::tag_t             complete_tag [issue_pkg::FU_COUNT]
);
    import issue_pkg::*;

    // Indexed by the fu_type_e encoding.
    localparam int unsigned FU_LAT [FU_COUNT] = '{ALU_LAT, MUL_LAT, LOAD_LAT, BR_LAT};
    // The sum bounds every single latency, so the counter never overflows.
    localparam int unsigned CNT_W = $clog2(ALU_LAT + MUL_LAT + LOAD_LAT + BR_LAT + 1);

    logic [CNT_W-1:0] cnt [FU_COUNT];              // Cycles left until completion, zero when idle.
    logic [CNT_W-1:0] cnt_nxt [FU_COUNT];

    always_comb begin
        for (int u = 0; u < FU_COUNT; u++) begin
            complete_valid[u] = (cnt[u] == CNT_W'(1));  // Last cycle of the operation.
            // Busy from the issue cycle up to, but not including, completion.
            fu_ready[u] = !issue_valid[u] && (cnt[u] <= CNT_W'(1));
            if (issue_valid[u]) begin
                cnt_nxt[u] = CNT_W'(FU_LAT[u]);    // Completion lands FU_LAT cycles later.
            end else if (cnt[u] != '0) begin
                cnt_nxt[u] = cnt[u] - CNT_W'(1);
            end else begin
                cnt_nxt[u] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int u = 0; u < FU_COUNT; u++) begin
                cnt[u] <= '0;                      // All units idle and ready.
            end
        end else begin
            cnt <= cnt_nxt;
        end
    end

    // The tag in flight, broadcast while complete_valid is high.
    always_ff @(posedge clk) begin
        for (int u = 0; u < FU_COUNT; u++) begin
            if (issue_valid[u]) complete_tag[u] <= issue_tag[u];
        end
    end

endmodule

//--- hdl/issue_pkg.sv
package issue_pkg;

    // Functional unit classes. The encoding doubles as the index into per-unit arrays.
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,                          // Integer ALU.
        FU_MUL    = 2'd1,                          // Multiplier.
        FU_LOAD   = 2'd2,                          // Load unit.
        FU_BRANCH = 2'd3                           // Branch resolution unit.
    } fu_type_e;

    typedef logic [3:0] tag_t;                     // Physical tag, 16 in flight at most.

    localparam int unsigned FU_COUNT = 4;          // One unit per class.

    localparam int unsigned ALU_LAT  = 1;          // Issue to completion, in cycles.
    localparam int unsigned BR_LAT   = 1;          // Branch resolves as fast as the ALU.
    localparam int unsigned LOAD_LAT = 2;          // Fixed hit latency, no misses modeled.
    localparam int unsigned MUL_LAT  = 3;          // Slowest unit, not pipelined.

    // True when any completion port broadcasts the given tag this cycle.
    function automatic logic tag_hit(input logic [FU_COUNT-1:0] cvalid,
                                     input tag_t ctag [FU_COUNT],
                                     input tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int u = 0; u < FU_COUNT; u++) begin
            if (cvalid[u] && (ctag[u] == tag)) hit = 1'b1;  // Any unit may produce it.
        end
        return hit;
    endfunction

endpackage

//--- hdl/issue_selector.sv
module issue_selector #(
    parameter int unsigned RS_DEPTH    = 8,
    parameter int unsigned ISSUE_WIDTH = 2
) (
    input  logic [issue_pkg::FU_COUNT-1:0] fu_ready,
    input  logic [RS_DEPTH-1:0]         rs_ready_vec,
    input  issue_pkg::fu_type_e         fu_types [RS_DEPTH],
    output logic [RS_DEPTH-1:0]         issue_rs_entry
);
    import issue_pkg::*;

    logic [FU_COUNT-1:0] type_used;                // Unit class already granted this cycle.
    int unsigned         issue_cnt;                // Grants made so far in the scan.
    logic                can_issue;                // Current entry passes every limit.

    // Lowest index wins, so older allocations in low slots are favored.
    always_comb begin
        issue_rs_entry = '0;
        type_used      = '0;
        issue_cnt      = 0;
        can_issue      = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            can_issue = rs_ready_vec[i]            // Entry is occupied and woken.
                     && (issue_cnt < ISSUE_WIDTH)  // Width budget not spent.
                     && fu_ready[fu_types[i]]      // Its unit can accept work.
                     && !type_used[fu_types[i]];   // One grant per unit class.
            if (can_issue) begin
                issue_rs_entry[i]        = 1'b1;
                type_used[fu_types[i]]   = 1'b1;
                issue_cnt                = issue_cnt + 1;
            end
        end
    end

endmodule

//--- hdl/issue_top.sv
module issue_top #(
    parameter int unsigned RS_DEPTH    = 8,
    parameter int unsigned ISSUE_WIDTH = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  issue_pkg::fu_type_e         in_fu_type,
    input  issue_pkg::tag_t             in_dest_tag,
    input  issue_pkg::tag_t             in_src_tag,
    input  logic                        in_src_ready,
    output logic                        in_ready,
    output logic [issue_pkg::FU_COUNT-1:0] issue_valid,
    output issue_pkg::tag_t             issue_tag [issue_pkg::FU_COUNT],
    output logic [issue_pkg::FU_COUNT-1:0] complete_valid,
    output issue_pkg::tag_t             complete_tag [issue_pkg::FU_COUNT]
);
    import issue_pkg::*;

    logic [RS_DEPTH-1:0] rs_ready_vec;             // Woken entries, station to selector.
    fu_type_e            fu_types [RS_DEPTH];      // Unit class of each entry.
    logic [RS_DEPTH-1:0] issue_rs_entry;           // Grants, selector back to station.
    logic [FU_COUNT-1:0] fu_ready;                 // Unit availability from the cluster.

    dispatch_if dsp_bus ();                        // Holding register to station path.

    dispatch_unit u_dispatch (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_fu_type     (in_fu_type),
        .in_dest_tag    (in_dest_tag),
        .in_src_tag     (in_src_tag),
        .in_src_ready   (in_src_ready),
        .in_ready       (in_ready),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .dsp            (dsp_bus.producer)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (
        .clk            (clk),
        .rst            (rst),
        .dsp            (dsp_bus.buffer),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .issue_rs_entry (issue_rs_entry),
        .rs_ready_vec   (rs_ready_vec),
        .fu_types       (fu_types),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag)
    );

    issue_selector #(.RS_DEPTH(RS_DEPTH), .ISSUE_WIDTH(ISSUE_WIDTH)) u_sel (
        .fu_ready       (fu_ready),
        .rs_ready_vec   (rs_ready_vec),
        .fu_types       (fu_types),
        .issue_rs_entry (issue_rs_entry)
    );

    fu_cluster u_fu (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag),
        .fu_ready       (fu_ready),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag)
    );

endmodule

//--- hdl/reservation_station.sv
module reservation_station #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    dispatch_if.buffer                  dsp,
    input  logic [issue_pkg::FU_COUNT-1:0] complete_valid,
    input  issue_pkg::tag_t             complete_tag [issue_pkg::FU_COUNT],
    input  logic [RS_DEPTH-1:0]         issue_rs_entry,
    output logic [RS_DEPTH-1:0]         rs_ready_vec,
    output issue_pkg::fu_type_e         fu_types [RS_DEPTH],
    output logic [issue_pkg::FU_COUNT-1:0] issue_valid,
    output issue_pkg::tag_t             issue_tag [issue_pkg::FU_COUNT]
);
    import issue_pkg::*;

    localparam int unsigned IDX_W = $clog2(RS_DEPTH);  // Entry index width.

    logic [RS_DEPTH-1:0] ent_valid;                // Entry holds an instruction.
    logic [RS_DEPTH-1:0] ent_src_rdy;              // Entry source operand is available.
    fu_type_e            ent_fu   [RS_DEPTH];
    tag_t                ent_dest [RS_DEPTH];
    tag_t                ent_src  [RS_DEPTH];
    logic [RS_DEPTH-1:0] wake;                     // Entry source matches a completion.
    logic [IDX_W-1:0]    alloc_idx;                // Lowest empty entry.
    logic                wr_en;

    assign dsp.has_free = ~&ent_valid;             // At least one slot is empty.
    assign wr_en        = dsp.valid && dsp.has_free;
    assign rs_ready_vec = ent_valid & ent_src_rdy; // Occupied and operand in hand.
    assign fu_types     = ent_fu;

    // Walk downward so the lowest empty index is the one left standing.
    always_comb begin
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) alloc_idx = IDX_W'(i);
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            wake[i] = tag_hit(complete_valid, complete_tag, ent_src[i]);  // Per-entry compare.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid   <= '0;
            ent_src_rdy <= '0;
            issue_valid <= '0;
        end else begin
            issue_valid <= '0;                     // Issue pulses last one cycle.
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (wake[i]) ent_src_rdy[i] <= 1'b1;
                if (issue_rs_entry[i]) begin
                    ent_valid[i]            <= 1'b0;  // Granted entry leaves the station.
                    issue_valid[ent_fu[i]]  <= 1'b1;  // Selector allows one grant per type.
                end
            end
            if (wr_en) begin
                ent_valid[alloc_idx]   <= 1'b1;    // Slot was empty, so no grant collides.
                ent_src_rdy[alloc_idx] <= dsp.src_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_rs_entry[i]) issue_tag[ent_fu[i]] <= ent_dest[i];  // Tag rides to the unit.
        end
        if (wr_en) begin
            ent_fu[alloc_idx]   <= dsp.fu_type;
            ent_dest[alloc_idx] <= dsp.dest_tag;
            ent_src[alloc_idx]  <= dsp.src_tag;
        end
    end

endmodule

//--- list.f
hdl/issue_pkg.sv
hdl/dispatch_if.sv
hdl/dispatch_unit.sv
hdl/reservation_station.sv
hdl/issue_selector.sv
hdl/fu_cluster.sv
hdl/issue_top.sv
tests/issue_assert.sv
tests/issue_tb.sv

//--- tests/issue_assert.sv
module issue_assert #(
    parameter int unsigned ISSUE_WIDTH = 2
) (
    input logic                            clk,
    input logic                            rst,
    input logic [issue_pkg::FU_COUNT-1:0]  fu_ready,
    input logic [issue_pkg::FU_COUNT-1:0]  issue_valid,
    input logic [issue_pkg::FU_COUNT-1:0]  complete_valid
);
    import issue_pkg::*;

    localparam int unsigned LAT [FU_COUNT] = '{ALU_LAT, MUL_LAT, LOAD_LAT, BR_LAT};  // By fu_type_e.

    // The selector budget caps the number of issue pulses per cycle.
    a_width: assert property (@(posedge clk) disable iff (rst)
        $countones(issue_valid) <= ISSUE_WIDTH)
        else $error("More issue pulses than the issue width allows.");

    for (genvar u = 0; u < FU_COUNT; u++) begin : g_unit
        localparam int unsigned LAT_U = LAT[u];    // Fixed latency of this unit.

        a_ready: assert property (@(posedge clk) disable iff (rst)
            issue_valid[u] |-> $past(fu_ready[u]))  // Grant was made on a free unit.
            else $error("Issue to unit %0d while it was busy.", u);

        a_lat: assert property (@(posedge clk) disable iff (rst)
            complete_valid[u] |-> $past(issue_valid[u], LAT_U))  // Completion trails issue.
            else $error("Completion on unit %0d without an issue at the fixed latency.", u);
    end

endmodule

bind issue_top issue_assert #(.ISSUE_WIDTH(ISSUE_WIDTH)) u_assert (
    .clk            (clk),
    .rst            (rst),
    .fu_ready       (fu_ready),
    .issue_valid    (issue_valid),
    .complete_valid (complete_valid)
);

//--- tests/issue_tb.sv
module issue_tb;
    import issue_pkg::*;

    localparam int unsigned RS_DEPTH    = 8;
    localparam int unsigned ISSUE_WIDTH = 2;
    localparam int unsigned RAND_COUNT  = 300;     // Instructions in the random run.
    localparam int unsigned DIR_CYCLES  = 200;     // Rough length of the directed part.
    localparam int unsigned LIMIT = DIR_CYCLES + RAND_COUNT * MUL_LAT + RS_DEPTH * MUL_LAT + 100;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic in_valid = 1'b0;
    fu_type_e in_fu_type = FU_ALU;
    tag_t in_dest_tag = '0;
    tag_t in_src_tag = '0;
    logic in_src_ready = 1'b0;
    logic in_ready;
    logic [FU_COUNT-1:0] issue_valid, complete_valid;
    tag_t issue_tag [FU_COUNT];
    tag_t complete_tag [FU_COUNT];

    // Reference state that mirrors the architectural timing of the stage.
    logic m_hv, m_hr;                              // Holding register valid and source ready.
    fu_type_e m_hf;
    tag_t m_hd, m_hs;
    logic [RS_DEPTH-1:0] m_ev, m_er;               // Entry valid and source ready.
    fu_type_e m_ef [RS_DEPTH];
    tag_t m_ed [RS_DEPTH];
    tag_t m_es [RS_DEPTH];
    logic [FU_COUNT-1:0] m_iv;                     // Expected issue pulses.
    tag_t m_it [FU_COUNT];
    int m_cnt [FU_COUNT];                          // Cycles left per unit.
    tag_t m_ct [FU_COUNT];
    int sent = 0;
    int issued = 0;
    int seq = 0;

    issue_top #(.RS_DEPTH(RS_DEPTH), .ISSUE_WIDTH(ISSUE_WIDTH)) u_dut (.*);

    always #2 clk = ~clk;                          // Period of 4.

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic int lat_of(input int u);
        case (u)
            0: return ALU_LAT;                     // ALU.
            1: return MUL_LAT;                     // Multiplier.
            2: return LOAD_LAT;                    // Load.
            default: return BR_LAT;                // Branch.
        endcase
    endfunction

    function automatic logic model_hit(input tag_t t);
        logic h;
        h = 1'b0;
        for (int u = 0; u < FU_COUNT; u++) if (m_cnt[u] == 1 && m_ct[u] == t) h = 1'b1;
        return h;
    endfunction

    // A tag is pending while its producer is anywhere between holding and completion.
    function automatic logic pending(input tag_t t);
        logic p;
        p = m_hv && (m_hd == t);
        for (int i = 0; i < RS_DEPTH; i++) if (m_ev[i] && m_ed[i] == t) p = 1'b1;
        for (int u = 0; u < FU_COUNT; u++) begin
            if ((m_iv[u] && m_it[u] == t) || (m_cnt[u] != 0 && m_ct[u] == t)) p = 1'b1;
        end
        return p;
    endfunction

    function automatic void reset_model();
        m_hv = 1'b0;
        m_hr = 1'b0;
        m_ev = '0;
        m_er = '0;
        m_iv = '0;
        for (int u = 0; u < FU_COUNT; u++) m_cnt[u] = 0;
    endfunction

    // One clock edge of the reference stage, inputs sampled at that edge.
    function automatic void step_model(input logic v, input fu_type_e f, input tag_t d,
                                       input tag_t s, input logic r);
        logic [FU_COUNT-1:0] fr, used, niv;
        logic [RS_DEPTH-1:0] gnt, wk;
        logic hf, acc, hand, hhit, ihit;
        int n, a;
        hf = ~&m_ev;
        acc = v && (!m_hv || hf);
        hand = m_hv && hf;
        hhit = model_hit(m_hs);
        ihit = model_hit(s);
        for (int u = 0; u < FU_COUNT; u++) fr[u] = !m_iv[u] && (m_cnt[u] <= 1);
        used = '0;
        niv = '0;
        gnt = '0;
        n = 0;
        a = 0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            wk[i] = model_hit(m_es[i]);
            if (m_ev[i] && m_er[i] && n < ISSUE_WIDTH && fr[m_ef[i]] && !used[m_ef[i]]) begin
                gnt[i] = 1'b1;                     // Lowest index wins its unit.
                used[m_ef[i]] = 1'b1;
                niv[m_ef[i]] = 1'b1;
                m_it[m_ef[i]] = m_ed[i];
                n++;
            end
        end
        for (int i = RS_DEPTH - 1; i >= 0; i--) if (!m_ev[i]) a = i;
        for (int u = 0; u < FU_COUNT; u++) begin
            if (m_iv[u]) begin
                m_cnt[u] = lat_of(u);
                m_ct[u] = m_it[u];
            end else if (m_cnt[u] != 0) begin
                m_cnt[u]--;
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wk[i]) m_er[i] = 1'b1;
            if (gnt[i]) m_ev[i] = 1'b0;
        end
        if (hand) begin
            m_ev[a] = 1'b1;                        // Lowest empty entry before this edge.
            m_er[a] = m_hr || hhit;
            m_ef[a] = m_hf;
            m_ed[a] = m_hd;
            m_es[a] = m_hs;
        end
        if (acc) begin
            m_hv = 1'b1;
            m_hf = f;
            m_hd = d;
            m_hs = s;
            m_hr = r || ihit;
        end else begin
            if (hand) m_hv = 1'b0;
            if (hhit) m_hr = 1'b1;
        end
        m_iv = niv;
    endfunction

    // The compare process steps the model and checks the outputs at each rising edge.
    always @(posedge clk) begin
        if (rst) reset_model();
        else step_model(in_valid, in_fu_type, in_dest_tag, in_src_tag, in_src_ready);
        #1;
        assert (in_ready === (!m_hv || !(&m_ev)))
            else abort_run($sformatf("Fail in_ready got %h expected %h", in_ready,
                                     !m_hv || !(&m_ev)));
        for (int u = 0; u < FU_COUNT; u++) begin
            assert (issue_valid[u] === m_iv[u])
                else abort_run($sformatf("Fail issue_valid[%0d] got %h expected %h", u,
                                         issue_valid[u], m_iv[u]));
            assert (!m_iv[u] || issue_tag[u] === m_it[u])
                else abort_run($sformatf("Fail issue_tag[%0d] got %h expected %h", u,
                                         issue_tag[u], m_it[u]));
            assert (complete_valid[u] === (m_cnt[u] == 1))
                else abort_run($sformatf("Fail complete_valid[%0d] got %h expected %h", u,
                                         complete_valid[u], m_cnt[u] == 1));
            assert (m_cnt[u] != 1 || complete_tag[u] === m_ct[u])
                else abort_run($sformatf("Fail complete_tag[%0d] got %h expected %h", u,
                                         complete_tag[u], m_ct[u]));
            if (issue_valid[u]) issued++;
        end
    end

    // Holds the instruction until accepted, refreshing readiness like a rename stage.
    task automatic send(input fu_type_e f, input tag_t d, input tag_t s);
        @(negedge clk);
        in_valid = 1'b1;
        in_fu_type = f;
        in_dest_tag = d;
        in_src_tag = s;
        in_src_ready = !pending(s);
        while (!in_ready) begin
            @(negedge clk);
            if (!pending(s)) in_src_ready = 1'b1;  // Producer finished while stalled.
        end
        sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    initial begin
        #(LIMIT * 4);
        $display("Timeout, the stage stopped making progress before all instructions issued.");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        void'($urandom(32'hd3f2ea61));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        send(FU_ALU, 4'd1, 4'd15);                 // Independent instructions of each type.
        idle(6);
        send(FU_MUL, 4'd2, 4'd15);
        idle(6);
        send(FU_LOAD, 4'd3, 4'd15);
        idle(6);
        send(FU_BRANCH, 4'd4, 4'd15);
        idle(6);
        send(FU_MUL, 4'd5, 4'd15);                 // Dependency on a multiply.
        send(FU_ALU, 4'd6, 4'd5);
        idle(8);
        send(FU_MUL, 4'd11, 4'd15);                // Several wake at once.
        send(FU_ALU, 4'd7, 4'd11);
        send(FU_LOAD, 4'd9, 4'd11);
        send(FU_BRANCH, 4'd10, 4'd11);
        send(FU_ALU, 4'd12, 4'd11);
        idle(10);
        send(FU_MUL, 4'd1, 4'd15);                 // The ALU keeps issuing behind a busy multiplier.
        send(FU_MUL, 4'd2, 4'd15);
        send(FU_MUL, 4'd3, 4'd15);
        send(FU_ALU, 4'd4, 4'd15);
        send(FU_ALU, 4'd5, 4'd15);
        idle(12);
        send(FU_MUL, 4'd13, 4'd15);                // A multiply chain keeps tag 0 pending.
        send(FU_MUL, 4'd14, 4'd13);
        send(FU_MUL, 4'd0, 4'd14);                 // Dependents fill the station.
        for (int k = 1; k <= 10; k++) send(FU_ALU, tag_t'(k), 4'd0);
        idle(20);
        for (int k = 0; k < RAND_COUNT; k++) begin
            seq++;
            if ($urandom_range(0, 3) == 0) begin
                send(fu_type_e'($urandom_range(0, 3)), tag_t'(seq),
                     tag_t'($urandom_range(0, 15)));
            end else begin
                send(fu_type_e'($urandom_range(0, 3)), tag_t'(seq),
                     tag_t'(seq - 1 - int'($urandom_range(0, 5))));
            end
        end
        idle(1);
        while (issued != sent) @(negedge clk);
        idle(8);
        $display("Result: PASSED");
        $finish;
    end

endmodule
